//--- verilog/rf_defines.svh
`ifndef RF_DEFINES_SVH
`define RF_DEFINES_SVH

// width of one data word
`define RF_XLEN 32

// architectural registers, x0 included
`define RF_NREGS 32

// register address width
`define RF_AW 5

// instructions entering per cycle
`define RF_LANES 2

`endif

//--- verilog/rf_pkg.sv
`default_nettype none

`include "rf_defines.svh"

package rf_pkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011
    } opcode_e;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4
    } alu_op_e;

    // register-register layout
    typedef struct packed {
        logic [6:0]        funct7;
        logic [`RF_AW-1:0] rs2;
        logic [`RF_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [`RF_AW-1:0] rd;
        logic [6:0]        opcode;
    } r_form_s;

    // immediate layout, same rs1/rd/opcode positions
    typedef struct packed {
        logic [11:0]       imm12;
        logic [`RF_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [`RF_AW-1:0] rd;
        logic [6:0]        opcode;
    } i_form_s;

    typedef union packed {
        r_form_s r_form;
        i_form_s i_form;
    } instr_u;

    // one decoded lane with its operands already resolved
    typedef struct packed {
        logic                valid;
        alu_op_e             alu_op;
        logic [`RF_AW-1:0]   rd;
        logic [`RF_XLEN-1:0] a;
        logic [`RF_XLEN-1:0] b;
    } issue_s;

endpackage

`default_nettype wire

//--- verilog/issue_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "rf_defines.svh"

// operand fetch to execute, one entry per lane
// no handshake, a lane only counts with its valid bit set
interface issue_if;

    rf_pkg::issue_s [`RF_LANES-1:0] lane;

    modport fetch (
        output lane
    );

    modport exec (
        input lane
    );

endinterface

`default_nettype wire

//--- verilog/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rf_defines.svh"

module regfile #(
    parameter int n_read  = 4,
    parameter int n_write = 2
) (
    input  wire logic                                 clk,
    input  wire logic                                 init,
    input  wire logic                                 flush,

    input  wire logic [n_read-1:0][`RF_AW-1:0]        rd_addr,
    output logic      [n_read-1:0][`RF_XLEN-1:0]      rd_data,

    input  wire logic [n_write-1:0]                   wr_en,
    input  wire logic [n_write-1:0][`RF_AW-1:0]       wr_addr,
    input  wire logic [n_write-1:0][`RF_XLEN-1:0]     wr_data
);

    logic [`RF_NREGS-1:0][`RF_XLEN-1:0] regs_r;
    logic [`RF_NREGS-1:0][`RF_XLEN-1:0] regs_next;

    // combinational reads, x0 forced to zero
    for (genvar i = 0; i < n_read; i++) begin : g_read
        assign rd_data[i] = (rd_addr[i] == '0) ? '0 : regs_r[rd_addr[i]];
    end

    // later write port wins on a shared address
    always_comb begin
        regs_next = regs_r;
        for (int p = 0; p < n_write; p++) begin
            if (wr_en[p] && (wr_addr[p] != '0)) begin
                regs_next[wr_addr[p]] = wr_data[p];
            end
        end
    end

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            regs_r <= '0;
        end else if (flush) begin
            regs_r <= '0;
        end else begin
            regs_r <= regs_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/operand_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "rf_defines.svh"

module operand_fetch (
    input  wire logic                                     clk,
    input  wire logic                                     init,
    input  wire logic                                     flush,

    input  wire logic [`RF_LANES-1:0]                     in_valid,
    input  wire logic [`RF_LANES-1:0][`RF_XLEN-1:0]       in_instr,

    output logic      [2*`RF_LANES-1:0][`RF_AW-1:0]       rd_addr,
    input  wire logic [2*`RF_LANES-1:0][`RF_XLEN-1:0]     rd_data,

    input  wire logic [`RF_LANES-1:0]                     wr_en,
    input  wire logic [`RF_LANES-1:0][`RF_AW-1:0]         wr_addr,
    input  wire logic [`RF_LANES-1:0][`RF_XLEN-1:0]       wr_data,

    input  wire logic [`RF_LANES-1:0][`RF_XLEN-1:0]       exec_result,

    issue_if.fetch                                        iss
);

    rf_pkg::issue_s [`RF_LANES-1:0] bundle_r;
    rf_pkg::issue_s [`RF_LANES-1:0] bundle_next;

    // newest older producer wins and lane 1 beats lane 0 within a stage
    function automatic logic [`RF_XLEN-1:0] fwd(
        input logic [`RF_AW-1:0]   src,
        input logic [`RF_XLEN-1:0] rf_val
    );
        logic [`RF_XLEN-1:0] val;
        val = rf_val;
        // writeback stage where wr_en already excludes x0
        for (int l = 0; l < `RF_LANES; l++) begin
            if (wr_en[l] && (wr_addr[l] == src)) begin
                val = wr_data[l];
            end
        end
        // group now in execute
        for (int l = 0; l < `RF_LANES; l++) begin
            if (bundle_r[l].valid && (bundle_r[l].rd != '0) && (bundle_r[l].rd == src)) begin
                val = exec_result[l];
            end
        end
        return val;
    endfunction

    // rs1 sits at the same bits in both views
    for (genvar l = 0; l < `RF_LANES; l++) begin : g_addr
        rf_pkg::instr_u word;
        assign word           = in_instr[l];
        assign rd_addr[2*l]   = word.r_form.rs1;
        assign rd_addr[2*l+1] = word.r_form.rs2;
    end

    always_comb begin
        rf_pkg::instr_u      w;
        rf_pkg::alu_op_e     op;
        logic                ok;
        logic                base_f7;
        logic [`RF_XLEN-1:0] imm;
        for (int l = 0; l < `RF_LANES; l++) begin
            w       = in_instr[l];
            op      = rf_pkg::ADD;
            ok      = 1'b0;
            base_f7 = (w.r_form.funct7 == 7'b0000000);
            imm     = {{(`RF_XLEN-12){w.i_form.imm12[11]}}, w.i_form.imm12};
            case (w.r_form.opcode)
                rf_pkg::OP: begin
                    case (w.r_form.funct3)
                        3'b000: begin
                            ok = base_f7 || (w.r_form.funct7 == 7'b0100000);
                            op = base_f7 ? rf_pkg::ADD : rf_pkg::SUB;
                        end
                        3'b111: begin
                            ok = base_f7;
                            op = rf_pkg::AND;
                        end
                        3'b110: begin
                            ok = base_f7;
                            op = rf_pkg::OR;
                        end
                        3'b100: begin
                            ok = base_f7;
                            op = rf_pkg::XOR;
                        end
                        default: ok = 1'b0;
                    endcase
                end
                // addi runs on the adder
                rf_pkg::OP_IMM: ok = (w.i_form.funct3 == 3'b000);
                default: ok = 1'b0;
            endcase
            bundle_next[l].valid  = in_valid[l] && ok;
            bundle_next[l].alu_op = op;
            bundle_next[l].rd     = w.r_form.rd;
            bundle_next[l].a      = fwd(w.r_form.rs1, rd_data[2*l]);
            if (w.r_form.opcode == rf_pkg::OP_IMM) begin
                bundle_next[l].b = imm;
            end else begin
                bundle_next[l].b = fwd(w.r_form.rs2, rd_data[2*l+1]);
            end
        end
    end

    // flush drops whatever was sampled this cycle
    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            bundle_r <= '0;
        end else if (flush) begin
            bundle_r <= '0;
        end else begin
            bundle_r <= bundle_next;
        end
    end

    assign iss.lane = bundle_r;

endmodule

`default_nettype wire

//--- verilog/int_exec.sv
`timescale 1ns/1ps
`default_nettype none

`include "rf_defines.svh"

module int_exec (
    input  wire logic                                 clk,
    input  wire logic                                 init,
    input  wire logic                                 flush,

    issue_if.exec                                     iss,

    output logic      [`RF_LANES-1:0][`RF_XLEN-1:0]   exec_result,

    output logic      [`RF_LANES-1:0]                 res_valid,
    output logic      [`RF_LANES-1:0]                 wr_en,
    output logic      [`RF_LANES-1:0][`RF_AW-1:0]     wr_addr,
    output logic      [`RF_LANES-1:0][`RF_XLEN-1:0]   wr_data
);

    logic [`RF_LANES-1:0]               valid_r;
    logic [`RF_LANES-1:0][`RF_AW-1:0]   rd_r;
    logic [`RF_LANES-1:0][`RF_XLEN-1:0] data_r;

    // both alus, also feeding the forwarding path
    always_comb begin
        for (int l = 0; l < `RF_LANES; l++) begin
            case (iss.lane[l].alu_op)
                rf_pkg::ADD: exec_result[l] = iss.lane[l].a + iss.lane[l].b;
                rf_pkg::SUB: exec_result[l] = iss.lane[l].a - iss.lane[l].b;
                rf_pkg::AND: exec_result[l] = iss.lane[l].a & iss.lane[l].b;
                rf_pkg::OR:  exec_result[l] = iss.lane[l].a | iss.lane[l].b;
                rf_pkg::XOR: exec_result[l] = iss.lane[l].a ^ iss.lane[l].b;
                default:     exec_result[l] = '0;
            endcase
        end
    end

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            valid_r <= '0;
        end else if (flush) begin
            valid_r <= '0;
        end else begin
            for (int l = 0; l < `RF_LANES; l++) begin
                valid_r[l] <= iss.lane[l].valid;
            end
        end
    end

    // result payload, qualified by valid_r
    always_ff @(posedge clk) begin
        for (int l = 0; l < `RF_LANES; l++) begin
            rd_r[l]   <= iss.lane[l].rd;
            data_r[l] <= exec_result[l];
        end
    end

    // x0 targets still report but never write
    for (genvar l = 0; l < `RF_LANES; l++) begin : g_wb
        assign wr_en[l] = valid_r[l] && (rd_r[l] != '0);
    end

    assign res_valid = valid_r;
    assign wr_addr   = rd_r;
    assign wr_data   = data_r;

endmodule

`default_nettype wire

//--- verilog/dual_issue_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rf_defines.svh"

module dual_issue_core (
    input  wire logic                                 clk,
    input  wire logic                                 init,
    input  wire logic                                 flush,

    input  wire logic [`RF_LANES-1:0]                 in_valid,
    input  wire logic [`RF_LANES-1:0][`RF_XLEN-1:0]   in_instr,

    output logic      [`RF_LANES-1:0]                 out_valid,
    output logic      [`RF_LANES-1:0][`RF_AW-1:0]     out_rd,
    output logic      [`RF_LANES-1:0][`RF_XLEN-1:0]   out_data
);

    // two read ports per lane
    logic [2*`RF_LANES-1:0][`RF_AW-1:0]   rd_addr;
    logic [2*`RF_LANES-1:0][`RF_XLEN-1:0] rd_data;

    logic [`RF_LANES-1:0]                 wr_en;
    logic [`RF_LANES-1:0][`RF_AW-1:0]     wr_addr;
    logic [`RF_LANES-1:0][`RF_XLEN-1:0]   wr_data;
    logic [`RF_LANES-1:0][`RF_XLEN-1:0]   exec_result;
    logic [`RF_LANES-1:0]                 res_valid;

    issue_if iss_i ();

    regfile #(
        .n_read  (2*`RF_LANES),
        .n_write (`RF_LANES)
    ) regfile_i (
        .clk     (clk),
        .init    (init),
        .flush   (flush),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    operand_fetch operand_fetch_i (
        .clk         (clk),
        .init        (init),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_instr    (in_instr),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .exec_result (exec_result),
        .iss         (iss_i.fetch)
    );

    int_exec int_exec_i (
        .clk         (clk),
        .init        (init),
        .flush       (flush),
        .iss         (iss_i.exec),
        .exec_result (exec_result),
        .res_valid   (res_valid),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

    // reported straight from the result registers
    assign out_valid = res_valid;
    assign out_rd    = wr_addr;
    assign out_data  = wr_data;

endmodule

`default_nettype wire

//--- tb/dual_issue_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "rf_defines.svh"

module dual_issue_chk (
    input  wire logic                                 clk,
    input  wire logic                                 init,
    input  wire logic                                 flush,
    input  wire logic [`RF_LANES-1:0]                 in_valid,
    input  wire logic [`RF_LANES-1:0][`RF_XLEN-1:0]   in_instr,
    input  wire logic [`RF_LANES-1:0]                 out_valid,
    input  wire logic [`RF_LANES-1:0]                 wr_en
);

    logic [`RF_AW-1:0] rd0;
    logic [`RF_AW-1:0] rd1;

    // destination field of each incoming word
    assign rd0 = in_instr[0][7 +: `RF_AW];
    assign rd1 = in_instr[1][7 +: `RF_AW];

    // one group never names the same nonzero destination twice
    dup_rd_a: assert property (@(posedge clk) disable iff (init)
        (in_valid[0] && in_valid[1] && (rd0 != '0)) |-> (rd0 != rd1))
        else $error("both lanes of a group write x%0d", rd0);

    // flush empties the whole pipe
    flush_drop_a: assert property (@(posedge clk) disable iff (init)
        flush |=> (out_valid == '0))
        else $error("result reported in the cycle after a flush");

    // a writeback traces back to a valid instruction two edges earlier
    for (genvar l = 0; l < `RF_LANES; l++) begin : g_lane
        wr_needs_valid_a: assert property (@(posedge clk) disable iff (init)
            wr_en[l] |-> (out_valid[l] && $past(in_valid[l], 2)))
            else $error("lane %0d writes back without a valid instruction behind it", l);
    end

endmodule

`default_nettype wire

//--- tb/dual_issue_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rf_defines.svh"

module dual_issue_tb;

    localparam int LAT = 2;
    localparam logic [6:0] F7_BASE = 7'h00;
    localparam logic [6:0] F7_SUB  = 7'h20;
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_XOR  = 3'b100;

    typedef struct {
        string       name;
        logic [1:0]  v;
        logic [31:0] i0;
        logic [31:0] i1;
        logic        fl;
    } vec_t;

    typedef struct {
        string                             name;
        logic [`RF_LANES-1:0]              valid;
        logic [`RF_LANES-1:0][`RF_AW-1:0]  rd;
        logic [`RF_LANES-1:0][`RF_XLEN-1:0] data;
    } exp_t;

    logic                                 clk;
    logic                                 init;
    logic                                 flush;
    logic [`RF_LANES-1:0]                 in_valid;
    logic [`RF_LANES-1:0][`RF_XLEN-1:0]   in_instr;
    logic [`RF_LANES-1:0]                 out_valid;
    logic [`RF_LANES-1:0][`RF_AW-1:0]     out_rd;
    logic [`RF_LANES-1:0][`RF_XLEN-1:0]   out_data;

    logic [`RF_XLEN-1:0] gold [`RF_NREGS];
    vec_t                vectors[$];
    exp_t                exp_q[$];
    logic [31:0]         rng_state;

    dual_issue_core dut_i (
        .clk       (clk),
        .init      (init),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .out_valid (out_valid),
        .out_rd    (out_rd),
        .out_data  (out_data)
    );

    bind dual_issue_core dual_issue_chk chk_i (
        .clk       (clk),
        .init      (init),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .out_valid (out_valid),
        .wr_en     (wr_en)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // reference ALU, returns 0 for encodings the slice does not execute
    function automatic logic model_alu(input logic [31:0] w, input logic [31:0] a,
                                       input logic [31:0] b, output logic [31:0] res);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = w[31:25];
        f3 = w[14:12];
        res = '0;
        if (w[6:0] == 7'b0010011) begin
            res = a + {{20{w[31]}}, w[31:20]};
            return f3 == F3_ADD;
        end
        if (w[6:0] != 7'b0110011) return 1'b0;
        if ((f3 == F3_ADD) && (f7 == F7_SUB)) begin
            res = a - b;
            return 1'b1;
        end
        if (f7 != F7_BASE) return 1'b0;
        case (f3)
            F3_ADD: res = a + b;
            F3_AND: res = a & b;
            F3_OR:  res = a | b;
            F3_XOR: res = a ^ b;
            default: return 1'b0;
        endcase
        return 1'b1;
    endfunction

    function automatic logic dup_dest(input logic [1:0] v, input logic [31:0] w0,
                                      input logic [31:0] w1);
        return (v == 2'b11) && (w0[11:7] != 5'd0) && (w0[11:7] == w1[11:7]);
    endfunction

    function automatic logic results_pending();
        foreach (exp_q[k]) begin
            if (exp_q[k].valid != '0) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic fail_value(input string name, input string what, input logic [31:0] exp,
                              input logic [31:0] act);
        $display("[FAIL] %s: %s expected 0x%08h actual 0x%08h", name, what, exp, act);
        abort_run();
    endtask

    task automatic fail_note(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    // whole group against the pre-group state, then both writes in lane order
    task automatic run_model(input string name, input logic [1:0] v, input logic [31:0] i0,
                             input logic [31:0] i1, output exp_t e);
        logic [1:0][31:0] w;
        logic [1:0][31:0] res;
        logic [1:0]       ok;
        w[0] = i0;
        w[1] = i1;
        for (int l = 0; l < `RF_LANES; l++) begin
            ok[l] = model_alu(w[l], gold[w[l][19:15]], gold[w[l][24:20]], res[l]);
            ok[l] = ok[l] && v[l];
        end
        e.name = name;
        for (int l = 0; l < `RF_LANES; l++) begin
            e.valid[l] = ok[l];
            e.rd[l]    = w[l][11:7];
            e.data[l]  = res[l];
        end
        for (int l = 0; l < `RF_LANES; l++) begin
            if (ok[l] && (w[l][11:7] != 5'd0)) gold[w[l][11:7]] = res[l];
        end
    endtask

    task automatic check_outputs();
        exp_t e;
        if (exp_q.size() < LAT) begin
            assert (out_valid == '0)
                else fail_value("startup", "out_valid", 32'h0, 32'(out_valid));
        end else begin
            e = exp_q.pop_front();
            assert (out_valid == e.valid)
                else fail_value(e.name, "out_valid", 32'(e.valid), 32'(out_valid));
            for (int l = 0; l < `RF_LANES; l++) begin
                if (e.valid[l]) begin
                    assert (out_rd[l] == e.rd[l])
                        else fail_value(e.name, "out_rd", 32'(e.rd[l]), 32'(out_rd[l]));
                    assert (out_data[l] == e.data[l])
                        else fail_value(e.name, "out_data", e.data[l], out_data[l]);
                end
            end
        end
    endtask

    // one cycle, check what comes out, then drive the next group
    task automatic step(input string name, input logic [1:0] v, input logic [31:0] i0,
                        input logic [31:0] i1, input logic fl);
        exp_t e;
        @(posedge clk);
        #5;
        check_outputs();
        if (fl) begin
            // group still in operand fetch never reaches the outputs
            if (exp_q.size() > 0) begin
                e = exp_q.pop_back();
                e.valid = '0;
                exp_q.push_back(e);
            end
            for (int r = 0; r < `RF_NREGS; r++) begin
                gold[r] = '0;
            end
            e.name  = name;
            e.valid = '0;
            exp_q.push_back(e);
        end else begin
            run_model(name, v, i0, i1, e);
            exp_q.push_back(e);
        end
        flush       = fl;
        in_valid    = v;
        in_instr[0] = i0;
        in_instr[1] = i1;
    endtask

    task automatic add_vec(input string name, input logic [1:0] v, input logic [31:0] i0,
                           input logic [31:0] i1, input logic fl);
        vec_t t;
        t.name = name;
        t.v    = v;
        t.i0   = i0;
        t.i1   = i1;
        t.fl   = fl;
        vectors.push_back(t);
    endtask

    // every register through addi/or with x0 as destination
    task automatic sweep_regs(input string name);
        for (int r = 0; r < 16; r++) begin
            step(name, 2'b11, i_word(12'h000, F3_ADD, 5'd0, 5'(r)),
                 r_word(F7_BASE, F3_OR, 5'd0, 5'(r + 16), 5'd0), 1'b0);
        end
    endtask

    task automatic load_vectors();
        add_vec("addi_zero_reset", 2'b11, i_word(12'h000, F3_ADD, 5'd1, 5'd5),
                i_word(12'h000, F3_ADD, 5'd2, 5'd31), 1'b0);
        add_vec("idle", 2'b00, 32'h0, 32'h0, 1'b0);
        add_vec("addi_imm", 2'b11, i_word(12'd100, F3_ADD, 5'd1, 5'd0),
                i_word(12'hff9, F3_ADD, 5'd2, 5'd0), 1'b0);
        add_vec("addi_sign", 2'b11, i_word(12'h800, F3_ADD, 5'd3, 5'd0),
                i_word(12'h7ff, F3_ADD, 5'd4, 5'd0), 1'b0);
        add_vec("dist1_dist2", 2'b11, r_word(F7_BASE, F3_ADD, 5'd5, 5'd3, 5'd4),
                r_word(F7_SUB, F3_ADD, 5'd6, 5'd1, 5'd2), 1'b0);
        add_vec("and_or_dist3", 2'b11, r_word(F7_BASE, F3_AND, 5'd7, 5'd5, 5'd6),
                r_word(F7_BASE, F3_OR, 5'd8, 5'd1, 5'd4), 1'b0);
        add_vec("same_group", 2'b11, i_word(12'd55, F3_ADD, 5'd9, 5'd0),
                r_word(F7_BASE, F3_ADD, 5'd10, 5'd9, 5'd9), 1'b0);
        add_vec("xor_sub_chain", 2'b11, r_word(F7_BASE, F3_XOR, 5'd11, 5'd9, 5'd3),
                r_word(F7_SUB, F3_ADD, 5'd12, 5'd10, 5'd7), 1'b0);
        add_vec("pre_group_read", 2'b11, i_word(12'hfff, F3_ADD, 5'd1, 5'd1),
                i_word(12'd1, F3_ADD, 5'd2, 5'd1), 1'b0);
        add_vec("x0_write", 2'b11, r_word(F7_BASE, F3_ADD, 5'd0, 5'd1, 5'd2),
                i_word(12'd5, F3_ADD, 5'd0, 5'd0), 1'b0);
        add_vec("x0_read", 2'b11, r_word(F7_BASE, F3_ADD, 5'd13, 5'd0, 5'd1),
                r_word(F7_BASE, F3_OR, 5'd14, 5'd0, 5'd0), 1'b0);
        add_vec("invalid_r", 2'b11, r_word(7'h01, F3_ADD, 5'd1, 5'd2, 5'd3),
                r_word(F7_BASE, 3'b001, 5'd2, 5'd1, 5'd1), 1'b0);
        // slti and a load word
        add_vec("invalid_i", 2'b11, i_word(12'h005, 3'b010, 5'd3, 5'd1), 32'h0000_2083, 1'b0);
        add_vec("after_invalid", 2'b11, r_word(F7_BASE, F3_ADD, 5'd15, 5'd1, 5'd2),
                r_word(F7_BASE, F3_ADD, 5'd16, 5'd3, 5'd4), 1'b0);
        add_vec("lane0_only", 2'b01, r_word(F7_SUB, F3_ADD, 5'd17, 5'd1, 5'd3),
                i_word(12'd1, F3_ADD, 5'd18, 5'd0), 1'b0);
        add_vec("lane1_only", 2'b10, i_word(12'd2, F3_ADD, 5'd18, 5'd0),
                r_word(F7_BASE, F3_ADD, 5'd18, 5'd18, 5'd17), 1'b0);
        add_vec("pre_flush", 2'b11, i_word(12'd77, F3_ADD, 5'd19, 5'd0),
                i_word(12'd88, F3_ADD, 5'd20, 5'd0), 1'b0);
        add_vec("flush", 2'b11, i_word(12'd1, F3_ADD, 5'd21, 5'd0),
                i_word(12'd2, F3_ADD, 5'd22, 5'd0), 1'b1);
        add_vec("post_flush", 2'b11, r_word(F7_BASE, F3_ADD, 5'd23, 5'd19, 5'd20),
                r_word(F7_BASE, F3_ADD, 5'd24, 5'd17, 5'd18), 1'b0);
        add_vec("idle", 2'b00, 32'h0, 32'h0, 1'b0);
    endtask

    task automatic random_lane(output logic [31:0] w);
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        r = xorshift32();
        // x0..x7 only, so lanes depend on each other often
        rd  = {2'b00, r[2:0]};
        rs1 = {2'b00, r[5:3]};
        rs2 = {2'b00, r[8:6]};
        case (r[12:10])
            3'd0: w = r_word(F7_BASE, F3_ADD, rd, rs1, rs2);
            3'd1: w = r_word(F7_SUB, F3_ADD, rd, rs1, rs2);
            3'd2: w = r_word(F7_BASE, F3_AND, rd, rs1, rs2);
            3'd3: w = r_word(F7_BASE, F3_OR, rd, rs1, rs2);
            3'd4: w = r_word(F7_BASE, F3_XOR, rd, rs1, rs2);
            3'd5, 3'd6: w = i_word(r[31:20], F3_ADD, rd, rs1);
            default: w = r_word(F7_BASE, 3'b101, rd, rs1, rs2);
        endcase
    endtask

    task automatic random_groups(input int count);
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] r;
        logic [1:0]  v;
        for (int n = 0; n < count; n++) begin
            for (int t = 0; t < 8; t++) begin
                random_lane(w0);
                random_lane(w1);
                r = xorshift32();
                v = r[1:0];
                if (!dup_dest(v, w0, w1)) break;
            end
            if (dup_dest(v, w0, w1)) v = 2'b01;
            step($sformatf("random_%0d", n), v, w0, w1, r[9:4] == 6'd0);
        end
    endtask

    initial begin
        int guard;
        rng_state = 32'h6f10e9c0;
        init      = 1'b1;
        flush     = 1'b0;
        in_valid  = '0;
        in_instr  = '0;
        for (int r = 0; r < `RF_NREGS; r++) begin
            gold[r] = '0;
        end
        repeat (2) @(posedge clk);
        #5;
        init = 1'b0;
        sweep_regs("sweep_after_reset");
        load_vectors();
        foreach (vectors[k]) begin
            step(vectors[k].name, vectors[k].v, vectors[k].i0, vectors[k].i1, vectors[k].fl);
        end
        sweep_regs("sweep_after_flush");
        random_groups(300);
        sweep_regs("sweep_final");
        guard = 0;
        while (results_pending() && (guard < 8)) begin
            step("drain", 2'b00, 32'h0, 32'h0, 1'b0);
            guard++;
        end
        if (results_pending()) begin
            fail_note("expected results were still queued when the drain timed out");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+verilog
verilog/rf_pkg.sv
verilog/issue_if.sv
verilog/regfile.sv
verilog/operand_fetch.sv
verilog/int_exec.sv
verilog/dual_issue_core.sv
tb/dual_issue_chk.sv
tb/dual_issue_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS := --lint-only --timing --assert --timescale 1ns/1ps -Wall
TOP       := dual_issue_tb
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "pass message not found in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
